//--- run.sh
#!/usr/bin/env bash
# Builds and runs the exec_cluster testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_exec_cluster -f vlog.f -o tb_exec_cluster
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_exec_cluster > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

//--- tests/exec_cluster_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_assertions (
  input logic                     gsi,
  input logic                     rst,
  input logic [ooo_pkg::ST_W-1:0] issue_st_type [2],
  input logic                     full_alu,
  input logic                     full_mul,
  input logic                     cdb_valid     [2],
  input logic                     mul_feed_valid
);
  import ooo_pkg::*;

  // ====================
  // issue protocol
  // ====================
  issue_alu_not_full: assert property (@(posedge gsi) disable iff (rst)
    (issue_st_type[0] == ST_ALU || issue_st_type[1] == ST_ALU) |-> !full_alu)
    else $error("issue to the alu station while it is full");

  issue_mul_not_full: assert property (@(posedge gsi) disable iff (rst)
    (issue_st_type[0] == ST_MUL || issue_st_type[1] == ST_MUL) |-> !full_mul)
    else $error("issue to the multiplier station while it is full");

  // ====================
  // cdb timing
  // ====================
  cdb_quiet_after_reset: assert property (@(posedge gsi)
    rst |=> !cdb_valid[0] && !cdb_valid[1])
    else $error("cdb valid right after reset");

  mul_latency: assert property (@(posedge gsi) disable iff (rst)
    cdb_valid[1] == $past(mul_feed_valid, MUL_LAT))
    else $error("lane 1 result does not follow the multiplier feed");

endmodule

bind exec_cluster exec_cluster_assertions exec_cluster_assertions_i (
  .gsi            (gsi),
  .rst            (rst),
  .issue_st_type  (issue_st_type),
  .full_alu       (full_alu),
  .full_mul       (full_mul),
  .cdb_valid      (cdb_valid),
  .mul_feed_valid (mul_feed_valid)
);

`default_nettype wire

//--- tests/exec_cluster_vectors.txt
# I cont lane st op src1 src2 v1 v2 data1 data2 imm rrn tag want expected (cont 1 = same cycle)
# F cont = flush, N = idle cycle, R = random idle gap, W = wait for all results
I 1 0 1 0 0 0 1 1 00000005 00000007 00000000 1 0 1 0000000c
I 0 1 2 8 0 0 1 1 00000007 fffffffd 00000000 10 0 1 ffffffeb
I 0 0 1 1 0 0 1 1 00000005 00000007 00000000 2 0 1 fffffffe
R
I 1 0 1 2 0 0 1 1 f0f0f0f0 0ff00ff0 00000000 3 0 1 00f000f0
I 0 1 2 9 0 0 1 1 00010000 00010000 00000000 11 0 1 00000001
I 0 0 1 3 0 0 1 1 f0f0f0f0 0ff00ff0 00000000 4 0 1 fff0fff0
I 1 0 1 4 0 0 1 1 f0f0f0f0 0ff00ff0 00000000 5 0 1 ff00ff00
I 0 1 2 9 0 0 1 1 ffffffff 00000002 00000000 12 0 1 ffffffff
R
I 1 0 1 5 0 0 1 1 ffffffff 00000001 00000000 6 0 1 00000001
I 0 1 1 5 0 0 1 1 00000001 ffffffff 00000000 7 0 1 00000000
I 1 0 1 6 0 0 1 1 00000003 00000024 00000000 8 0 1 00000030
I 0 1 2 8 0 0 1 1 12345678 00000010 00000000 13 0 1 23456780
I 0 0 1 7 0 0 1 1 00000010 00000000 fffffffc 9 0 1 0000000c
W
# dependent chain across both stations
I 0 0 1 0 0 0 1 1 00000003 00000004 00000000 20 0 1 00000007
I 0 1 2 8 20 0 0 1 00000000 00000006 00000000 21 0 1 0000002a
I 0 0 1 7 21 0 0 1 00000000 00000000 00000008 22 0 1 00000032
I 0 1 1 1 22 0 0 1 00000000 00000007 00000000 23 0 1 0000002b
I 0 0 2 8 23 22 0 0 00000000 00000000 00000000 24 0 1 00000866
W
# consumers issued in the cycle rrn 30 is broadcast
I 0 0 1 0 0 0 1 1 00000100 00000023 00000000 30 0 1 00000123
N
N
I 1 0 1 0 30 0 0 1 00000000 00000001 00000000 31 0 1 00000124
I 0 1 2 8 30 0 0 1 00000000 00000002 00000000 32 0 1 00000246
W
# flush
I 1 0 1 0 50 0 0 1 00000000 00000001 00000000 40 1 0 00000000
I 0 1 2 8 50 0 0 1 00000000 00000002 00000000 41 1 0 00000000
I 0 0 1 0 0 0 1 1 00000002 00000002 00000000 42 0 1 00000004
I 0 0 1 4 51 0 0 1 00000000 0000ffff 00000000 43 0 1 0000ffcc
F 1
I 1 0 1 0 0 0 1 1 00000001 00000001 00000000 44 1 0 00000000
I 0 1 2 8 0 0 1 1 00000003 00000003 00000000 45 0 1 00000009
I 1 0 1 0 0 0 1 1 00000010 00000020 00000000 50 0 1 00000030
I 0 1 2 8 0 0 1 1 00000011 00000003 00000000 51 0 1 00000033
W
# capacity, alu entries wait on a slow multiplier chain
I 1 0 2 8 0 0 1 1 00000002 00000003 00000000 56 0 1 00000006
I 0 1 2 8 56 0 0 1 00000000 00000002 00000000 57 0 1 0000000c
I 1 0 2 8 57 0 0 1 00000000 00000002 00000000 58 0 1 00000018
I 0 1 2 8 58 0 0 1 00000000 00000002 00000000 59 0 1 00000030
I 0 0 2 8 59 0 0 1 00000000 00000002 00000000 60 0 1 00000060
I 0 0 1 7 60 0 0 1 00000000 00000000 00000001 61 0 1 00000061
I 0 1 1 7 60 0 0 1 00000000 00000000 00000002 62 0 1 00000062
I 0 0 1 7 60 0 0 1 00000000 00000000 00000003 63 0 1 00000063
I 0 1 1 7 60 0 0 1 00000000 00000000 00000004 64 0 1 00000064
I 0 0 1 7 60 0 0 1 00000000 00000000 00000005 65 0 1 00000065
I 0 1 1 7 60 0 0 1 00000000 00000000 00000006 66 0 1 00000066
I 0 0 1 7 60 0 0 1 00000000 00000000 00000007 67 0 1 00000067
I 0 1 1 7 60 0 0 1 00000000 00000000 00000008 68 0 1 00000068
I 0 0 1 7 60 0 0 1 00000000 00000000 00000009 69 0 1 00000069

//--- tests/tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
  import ooo_pkg::*;

  localparam int TIMEOUT = 300;   // cycles per wait loop.

  int seed = 99270;

  logic             gsi = 1'b0;
  logic             rst;
  logic             delete_tagged;
  logic [ST_W-1:0]  issue_st_type [2];
  logic [OP_W-1:0]  issue_op      [2];
  logic [TAG_W-1:0] issue_src_1   [2];
  logic [TAG_W-1:0] issue_src_2   [2];
  logic             issue_valid_1 [2];
  logic             issue_valid_2 [2];
  logic [XLEN-1:0]  issue_data_1  [2];
  logic [XLEN-1:0]  issue_data_2  [2];
  logic [XLEN-1:0]  issue_imm     [2];
  logic [TAG_W-1:0] issue_rrn     [2];
  logic             issue_tag     [2];
  logic             full_alu;
  logic             full_mul;
  logic             cdb_valid     [2];
  logic [TAG_W-1:0] cdb_rrn       [2];
  logic [XLEN-1:0]  cdb_result    [2];

  // ====================
  // expected table, indexed by rrn.
  // ====================
  logic [XLEN-1:0] exp_val [64];
  bit              known   [64];
  bit              want    [64];   // 0 marks a result that a flush must remove.
  bit              seen    [64];
  int              lane_of [64];
  int              errors;
  int              checks;
  int              pending;
  bit              issued_any;
  bit              aborted;
  bit              full_alu_rose;   // the capacity run fills the alu station.

  // the issue group that goes out in one cycle.
  logic [ST_W-1:0]  g_st [2];
  logic [OP_W-1:0]  g_op [2];
  logic [TAG_W-1:0] g_s1 [2];
  logic [TAG_W-1:0] g_s2 [2];
  logic             g_v1 [2];
  logic             g_v2 [2];
  logic [XLEN-1:0]  g_d1 [2];
  logic [XLEN-1:0]  g_d2 [2];
  logic [XLEN-1:0]  g_im [2];
  logic [TAG_W-1:0] g_rrn [2];
  logic             g_tag [2];
  logic             g_flush;

  exec_cluster exec_cluster_i (.*);

  always #20 gsi = ~gsi;

  task automatic clear_group();
    for (int k = 0; k < 2; k++) begin
      g_st[k] = ST_NONE;
      g_op[k] = '0;
      g_s1[k] = '0;
      g_s2[k] = '0;
      g_v1[k] = 1'b0;
      g_v2[k] = 1'b0;
      g_d1[k] = '0;
      g_d2[k] = '0;
      g_im[k] = '0;
      g_rrn[k] = '0;
      g_tag[k] = 1'b0;
    end
    g_flush = 1'b0;
  endtask

  task automatic drive_idle();
    @(posedge gsi);
    for (int k = 0; k < 2; k++) begin
      issue_st_type[k] <= ST_NONE;
    end
    delete_tagged <= 1'b0;
  endtask

  task automatic drive_group();
    @(posedge gsi);
    // a source whose producer has already broadcast comes with its value, as rename supplies it.
    for (int k = 0; k < 2; k++) begin
      if (!g_v1[k] && seen[g_s1[k]]) begin
        g_v1[k] = 1'b1;
        g_d1[k] = exp_val[g_s1[k]];
      end
      if (!g_v2[k] && seen[g_s2[k]]) begin
        g_v2[k] = 1'b1;
        g_d2[k] = exp_val[g_s2[k]];
      end
    end
    for (int k = 0; k < 2; k++) begin
      issue_st_type[k] <= g_st[k];
      issue_op[k]      <= g_op[k];
      issue_src_1[k]   <= g_s1[k];
      issue_src_2[k]   <= g_s2[k];
      issue_valid_1[k] <= g_v1[k];
      issue_valid_2[k] <= g_v2[k];
      issue_data_1[k]  <= g_d1[k];
      issue_data_2[k]  <= g_d2[k];
      issue_imm[k]     <= g_im[k];
      issue_rrn[k]     <= g_rrn[k];
      issue_tag[k]     <= g_tag[k];
      if (g_st[k] != ST_NONE) issued_any = 1'b1;
    end
    delete_tagged <= g_flush;
  endtask

  // a station takes the group only when it is not full and no issue to it is still in flight.
  function automatic bit station_free(input logic [ST_W-1:0] st);
    bit busy;
    busy = (st == ST_ALU) ? full_alu : full_mul;
    return !(busy || issue_st_type[0] == st || issue_st_type[1] == st);
  endfunction

  function automatic bit can_issue();
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < 2; k++) begin
      if (g_st[k] != ST_NONE && !station_free(g_st[k])) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic send_group();
    int n;
    n = 0;
    @(negedge gsi);
    while (!can_issue() && n < TIMEOUT) begin
      drive_idle();
      @(negedge gsi);
      n++;
    end
    if (!can_issue()) begin
      $display("timeout: a station stayed full at %0t ns", $time);
      errors++;
      aborted = 1'b1;
    end else begin
      drive_group();
    end
    clear_group();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    drive_idle();
    while (pending != 0 && n < TIMEOUT) begin
      @(negedge gsi);
      n++;
    end
    if (pending != 0) begin
      $display("timeout: %0d expected results never appeared", pending);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // ====================
  // cdb scoreboard
  // ====================
  always @(negedge gsi) begin
    logic [TAG_W-1:0] r;
    if (!rst) begin
      if (full_alu) full_alu_rose = 1'b1;
      for (int k = 0; k < 2; k++) begin
        if (cdb_valid[k]) begin
          r = cdb_rrn[k];
          checks++;
          assert (issued_any) else begin
            $display("cdb lane %0d went valid before the first issue", k);
            errors++;
          end
          assert (known[r] && want[r]) else begin
            $display("rrn %0d appeared but was never expected", r);
            errors++;
          end
          assert (!seen[r]) else begin
            $display("rrn %0d appeared twice", r);
            errors++;
          end
          assert (lane_of[r] == k) else begin
            $display("rrn %0d came on the wrong cdb lane %0d", r, k);
            errors++;
          end
          assert (cdb_result[k] === exp_val[r]) else begin
            $display("[FAIL] %0t ns: rrn %0d result %h, expected %h", $time, r,
                     cdb_result[k], exp_val[r]);
            errors++;
          end
          if (want[r] && !seen[r]) pending--;
          seen[r] = 1'b1;
        end
      end
    end
  end

  initial begin
    int fd;
    int c;
    int cont;
    int lane;
    int gap;
    logic [7:0] ch;
    logic [ST_W-1:0] st;
    logic [OP_W-1:0] op;
    logic [TAG_W-1:0] s1;
    logic [TAG_W-1:0] s2;
    logic [TAG_W-1:0] rrn;
    logic v1;
    logic v2;
    logic tg;
    logic wt;
    logic [XLEN-1:0] d1;
    logic [XLEN-1:0] d2;
    logic [XLEN-1:0] im;
    logic [XLEN-1:0] ex;
    string line;
    rst = 1'b1;
    delete_tagged = 1'b0;
    clear_group();
    for (int k = 0; k < 2; k++) begin
      issue_st_type[k] = ST_NONE;
      issue_op[k] = '0;
      issue_src_1[k] = '0;
      issue_src_2[k] = '0;
      issue_valid_1[k] = 1'b0;
      issue_valid_2[k] = 1'b0;
      issue_data_1[k] = '0;
      issue_data_2[k] = '0;
      issue_imm[k] = '0;
      issue_rrn[k] = '0;
      issue_tag[k] = 1'b0;
    end
    fd = $fopen("tests/exec_cluster_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file");
      errors++;
      aborted = 1'b1;
    end
    repeat (16) @(posedge gsi);
    rst <= 1'b0;
    @(negedge gsi);
    assert (!full_alu && !full_mul) else begin
      $display("[FAIL] %0t ns: full is high after reset", $time);
      errors++;
    end
    while (!aborted) begin
      c = $fgetc(fd);
      if (c == -1) break;
      ch = c[7:0];
      case (ch)
        "#": void'($fgets(line, fd));
        "I": begin
          void'($fscanf(fd, "%d %d %d %d %d %d %d %d %h %h %h %d %d %d %h", cont, lane, st,
                        op, s1, s2, v1, v2, d1, d2, im, rrn, tg, wt, ex));
          g_st[lane] = st;
          g_op[lane] = op;
          g_s1[lane] = s1;
          g_s2[lane] = s2;
          g_v1[lane] = v1;
          g_v2[lane] = v2;
          g_d1[lane] = d1;
          g_d2[lane] = d2;
          g_im[lane] = im;
          g_rrn[lane] = rrn;
          g_tag[lane] = tg;
          known[rrn] = 1'b1;
          want[rrn] = wt;
          seen[rrn] = 1'b0;
          exp_val[rrn] = ex;
          lane_of[rrn] = (st == ST_MUL) ? 1 : 0;
          if (wt) pending++;
          if (cont == 0) send_group();
        end
        "F": begin
          void'($fscanf(fd, "%d", cont));
          g_flush = 1'b1;
          if (cont == 0) send_group();
        end
        "N": drive_idle();
        "R": begin
          gap = $unsigned($random(seed)) % 4;
          repeat (gap) drive_idle();
        end
        "W": wait_drain();
        default: ;   // whitespace between lines.
      endcase
    end
    if (!aborted) wait_drain();
    repeat (20) @(negedge gsi);   // late or repeated results would show here.
    assert (full_alu_rose) else begin
      $display("the alu station never reported full while it filled up");
      errors++;
    end
    $display("checks %0d, errors %0d, missing %0d", checks, errors, pending);
    if (errors == 0 && !aborted) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic                      gsi,
  input  logic                      rst,
  input  logic                      feed_valid,
  input  logic [ooo_pkg::OP_W-1:0]  feed_op,
  input  logic [ooo_pkg::XLEN-1:0]  feed_data_1,
  input  logic [ooo_pkg::XLEN-1:0]  feed_data_2,
  input  logic [ooo_pkg::XLEN-1:0]  feed_imm,
  input  logic [ooo_pkg::TAG_W-1:0] feed_rrn,
  output logic                      cdb_valid,
  output logic [ooo_pkg::TAG_W-1:0] cdb_rrn,
  output logic [ooo_pkg::XLEN-1:0]  cdb_result
);
  import ooo_pkg::*;

  logic [XLEN-1:0] result;

  always_comb begin
    case (feed_op)
      OP_ADD:  result = feed_data_1 + feed_data_2;
      OP_SUB:  result = feed_data_1 - feed_data_2;
      OP_AND:  result = feed_data_1 & feed_data_2;
      OP_OR:   result = feed_data_1 | feed_data_2;
      OP_XOR:  result = feed_data_1 ^ feed_data_2;
      OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(feed_data_1) < $signed(feed_data_2)};
      OP_SLL:  result = feed_data_1 << feed_data_2[4:0];
      OP_ADDI: result = feed_data_1 + feed_imm;
      default: result = '0;   // multiplier codes never reach this station.
    endcase
  end

  always_ff @(posedge gsi) begin
    if (rst) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= feed_valid;
    end
  end

  always_ff @(posedge gsi) begin
    cdb_rrn    <= feed_rrn;
    cdb_result <= result;
  end

endmodule

`default_nettype wire

//--- verilog/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  logic                      gsi,
  input  logic                      rst,
  input  logic                      delete_tagged,
  input  logic [ooo_pkg::ST_W-1:0]  issue_st_type [2],
  input  logic [ooo_pkg::OP_W-1:0]  issue_op      [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_src_1   [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_src_2   [2],
  input  logic                      issue_valid_1 [2],
  input  logic                      issue_valid_2 [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_data_1  [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_data_2  [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_imm     [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_rrn     [2],
  input  logic                      issue_tag     [2],
  output logic                      full_alu,
  output logic                      full_mul,
  output logic                      cdb_valid     [2],
  output logic [ooo_pkg::TAG_W-1:0] cdb_rrn       [2],
  output logic [ooo_pkg::XLEN-1:0]  cdb_result    [2]
);
  import ooo_pkg::*;

  // ====================
  // alu path, cdb lane 0.
  // ====================
  logic             alu_feed_valid;
  logic [OP_W-1:0]  alu_feed_op;
  logic [XLEN-1:0]  alu_feed_data_1;
  logic [XLEN-1:0]  alu_feed_data_2;
  logic [XLEN-1:0]  alu_feed_imm;
  logic [TAG_W-1:0] alu_feed_rrn;

  reservation_station #(.ST_TYPE(ST_ALU)) rs_alu_i (
    .*,
    .full        (full_alu),
    .feed_valid  (alu_feed_valid),
    .feed_op     (alu_feed_op),
    .feed_data_1 (alu_feed_data_1),
    .feed_data_2 (alu_feed_data_2),
    .feed_imm    (alu_feed_imm),
    .feed_rrn    (alu_feed_rrn)
  );

  alu_unit alu_unit_i (
    .gsi,
    .rst,
    .feed_valid  (alu_feed_valid),
    .feed_op     (alu_feed_op),
    .feed_data_1 (alu_feed_data_1),
    .feed_data_2 (alu_feed_data_2),
    .feed_imm    (alu_feed_imm),
    .feed_rrn    (alu_feed_rrn),
    .cdb_valid   (cdb_valid[0]),
    .cdb_rrn     (cdb_rrn[0]),
    .cdb_result  (cdb_result[0])
  );

  // ====================
  // multiplier path, cdb lane 1.
  // ====================
  logic             mul_feed_valid;
  logic [OP_W-1:0]  mul_feed_op;
  logic [XLEN-1:0]  mul_feed_data_1;
  logic [XLEN-1:0]  mul_feed_data_2;
  logic [TAG_W-1:0] mul_feed_rrn;

  reservation_station #(.ST_TYPE(ST_MUL)) rs_mul_i (
    .*,
    .full        (full_mul),
    .feed_valid  (mul_feed_valid),
    .feed_op     (mul_feed_op),
    .feed_data_1 (mul_feed_data_1),
    .feed_data_2 (mul_feed_data_2),
    .feed_imm    (),   // products take no immediate.
    .feed_rrn    (mul_feed_rrn)
  );

  mul_unit mul_unit_i (
    .gsi,
    .rst,
    .feed_valid  (mul_feed_valid),
    .feed_op     (mul_feed_op),
    .feed_data_1 (mul_feed_data_1),
    .feed_data_2 (mul_feed_data_2),
    .feed_rrn    (mul_feed_rrn),
    .cdb_valid   (cdb_valid[1]),
    .cdb_rrn     (cdb_rrn[1]),
    .cdb_result  (cdb_result[1])
  );

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic                      gsi,
  input  logic                      rst,
  input  logic                      feed_valid,
  input  logic [ooo_pkg::OP_W-1:0]  feed_op,
  input  logic [ooo_pkg::XLEN-1:0]  feed_data_1,
  input  logic [ooo_pkg::XLEN-1:0]  feed_data_2,
  input  logic [ooo_pkg::TAG_W-1:0] feed_rrn,
  output logic                      cdb_valid,
  output logic [ooo_pkg::TAG_W-1:0] cdb_rrn,
  output logic [ooo_pkg::XLEN-1:0]  cdb_result
);
  import ooo_pkg::*;

  // stage 1 holds two partial products, split on the halves of operand 2.
  logic signed [XLEN+XLEN/2:0]   s1_pp_lo;   // times the unsigned low half.
  logic signed [XLEN+XLEN/2-1:0] s1_pp_hi;   // times the signed high half.
  logic        [2*XLEN-1:0]      s2_prod;

  // valid, opcode and rrn ride along with the data stages.
  logic             sb_valid [MUL_LAT-1];
  logic [OP_W-1:0]  sb_op    [MUL_LAT-1];
  logic [TAG_W-1:0] sb_rrn   [MUL_LAT-1];

  always_ff @(posedge gsi) begin
    s1_pp_lo <= $signed(feed_data_1) * $signed({1'b0, feed_data_2[XLEN/2-1:0]});
    s1_pp_hi <= $signed(feed_data_1) * $signed(feed_data_2[XLEN-1:XLEN/2]);
    s2_prod  <= {s1_pp_hi, {(XLEN/2){1'b0}}} +
                {{(XLEN/2-1){s1_pp_lo[XLEN+XLEN/2]}}, s1_pp_lo};
    cdb_result <= (sb_op[MUL_LAT-2] == OP_MULH) ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
  end

  always_ff @(posedge gsi) begin
    if (rst) begin
      for (int i = 0; i < MUL_LAT-1; i++) begin
        sb_valid[i] <= 1'b0;
      end
      cdb_valid <= 1'b0;
    end else begin
      sb_valid[0] <= feed_valid;
      for (int i = 1; i < MUL_LAT-1; i++) begin
        sb_valid[i] <= sb_valid[i-1];
      end
      cdb_valid <= sb_valid[MUL_LAT-2];
    end
  end

  always_ff @(posedge gsi) begin
    sb_op[0]  <= feed_op;
    sb_rrn[0] <= feed_rrn;
    for (int i = 1; i < MUL_LAT-1; i++) begin
      sb_op[i]  <= sb_op[i-1];
      sb_rrn[i] <= sb_rrn[i-1];
    end
    cdb_rrn <= sb_rrn[MUL_LAT-2];
  end

endmodule

`default_nettype wire

//--- verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // ====================
  // widths and sizes.
  // ====================
  localparam int XLEN    = 32;
  localparam int TAG_W   = 6;
  localparam int RS_SIZE = 8;   // entries per station.
  localparam int MUL_LAT = 3;   // feed to cdb lane 1, in cycles.

  // ====================
  // station types.
  // ====================
  localparam int ST_W = 2;

  localparam logic [ST_W-1:0] ST_NONE = 2'd0;   // the lane carries nothing this cycle.
  localparam logic [ST_W-1:0] ST_ALU  = 2'd1;
  localparam logic [ST_W-1:0] ST_MUL  = 2'd2;

  // ====================
  // opcodes.
  // ====================
  localparam int OP_W = 4;

  localparam logic [OP_W-1:0] OP_ADD  = 4'd0;
  localparam logic [OP_W-1:0] OP_SUB  = 4'd1;
  localparam logic [OP_W-1:0] OP_AND  = 4'd2;
  localparam logic [OP_W-1:0] OP_OR   = 4'd3;
  localparam logic [OP_W-1:0] OP_XOR  = 4'd4;
  localparam logic [OP_W-1:0] OP_SLT  = 4'd5;   // signed compare.
  localparam logic [OP_W-1:0] OP_SLL  = 4'd6;   // shift by the low 5 bits of operand 2.
  localparam logic [OP_W-1:0] OP_ADDI = 4'd7;   // operand 1 plus the immediate.
  localparam logic [OP_W-1:0] OP_MUL  = 4'd8;   // low word of the signed product.
  localparam logic [OP_W-1:0] OP_MULH = 4'd9;   // high word of the signed product.

endpackage

`default_nettype wire

//--- verilog/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter logic [ooo_pkg::ST_W-1:0] ST_TYPE = ooo_pkg::ST_ALU
) (
  input  logic                      gsi,
  input  logic                      rst,
  input  logic                      delete_tagged,
  input  logic [ooo_pkg::ST_W-1:0]  issue_st_type [2],
  input  logic [ooo_pkg::OP_W-1:0]  issue_op      [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_src_1   [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_src_2   [2],
  input  logic                      issue_valid_1 [2],
  input  logic                      issue_valid_2 [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_data_1  [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_data_2  [2],
  input  logic [ooo_pkg::XLEN-1:0]  issue_imm     [2],
  input  logic [ooo_pkg::TAG_W-1:0] issue_rrn     [2],
  input  logic                      issue_tag     [2],
  input  logic                      cdb_valid     [2],
  input  logic [ooo_pkg::TAG_W-1:0] cdb_rrn       [2],
  input  logic [ooo_pkg::XLEN-1:0]  cdb_result    [2],
  output logic                      full,
  output logic                      feed_valid,
  output logic [ooo_pkg::OP_W-1:0]  feed_op,
  output logic [ooo_pkg::XLEN-1:0]  feed_data_1,
  output logic [ooo_pkg::XLEN-1:0]  feed_data_2,
  output logic [ooo_pkg::XLEN-1:0]  feed_imm,
  output logic [ooo_pkg::TAG_W-1:0] feed_rrn
);
  import ooo_pkg::*;

  // entry array, index 0 is the oldest.
  logic             e_busy    [RS_SIZE];
  logic [OP_W-1:0]  e_op      [RS_SIZE];
  logic [TAG_W-1:0] e_src_1   [RS_SIZE];
  logic [TAG_W-1:0] e_src_2   [RS_SIZE];
  logic             e_valid_1 [RS_SIZE];
  logic             e_valid_2 [RS_SIZE];
  logic [XLEN-1:0]  e_data_1  [RS_SIZE];
  logic [XLEN-1:0]  e_data_2  [RS_SIZE];
  logic [XLEN-1:0]  e_imm     [RS_SIZE];
  logic [TAG_W-1:0] e_rrn     [RS_SIZE];
  logic             e_tag     [RS_SIZE];

  logic             n_busy    [RS_SIZE];
  logic [OP_W-1:0]  n_op      [RS_SIZE];
  logic [TAG_W-1:0] n_src_1   [RS_SIZE];
  logic [TAG_W-1:0] n_src_2   [RS_SIZE];
  logic             n_valid_1 [RS_SIZE];
  logic             n_valid_2 [RS_SIZE];
  logic [XLEN-1:0]  n_data_1  [RS_SIZE];
  logic [XLEN-1:0]  n_data_2  [RS_SIZE];
  logic [XLEN-1:0]  n_imm     [RS_SIZE];
  logic [TAG_W-1:0] n_rrn     [RS_SIZE];
  logic             n_tag     [RS_SIZE];

  logic sel [RS_SIZE];   // one-hot, the oldest ready entry.
  logic sel_any;

  // an operand still waiting takes the value of a matching cdb lane.
  function automatic logic [XLEN:0] capture(input logic [TAG_W-1:0] src, input logic vld,
                                            input logic [XLEN-1:0] data);
    logic [XLEN:0] res;
    res = {vld, data};
    for (int k = 0; k < 2; k++) begin
      if (!vld && cdb_valid[k] && cdb_rrn[k] == src) begin
        res = {1'b1, cdb_result[k]};
      end
    end
    return res;
  endfunction

  // entries are compacted, so the busy bits form a thermometer code.
  assign full = e_busy[RS_SIZE-2];

  // ====================
  // select
  // ====================
  always_comb begin
    sel_any = 1'b0;
    for (int i = 0; i < RS_SIZE; i++) begin
      sel[i] = 1'b0;
      if (!sel_any && e_busy[i] && e_valid_1[i] && e_valid_2[i] &&
          !(delete_tagged && e_tag[i])) begin
        sel[i]  = 1'b1;
        sel_any = 1'b1;
      end
    end
  end

  // ====================
  // next entry array
  // ====================
  always_comb begin
    int wr;
    wr = 0;
    for (int i = 0; i < RS_SIZE; i++) begin
      n_busy[i]    = 1'b0;
      n_op[i]      = e_op[i];
      n_src_1[i]   = e_src_1[i];
      n_src_2[i]   = e_src_2[i];
      n_valid_1[i] = e_valid_1[i];
      n_valid_2[i] = e_valid_2[i];
      n_data_1[i]  = e_data_1[i];
      n_data_2[i]  = e_data_2[i];
      n_imm[i]     = e_imm[i];
      n_rrn[i]     = e_rrn[i];
      n_tag[i]     = e_tag[i];
    end
    // surviving entries slide down over the ones that leave.
    for (int i = 0; i < RS_SIZE; i++) begin
      if (e_busy[i] && !sel[i] && !(delete_tagged && e_tag[i])) begin
        n_busy[wr]  = 1'b1;
        n_op[wr]    = e_op[i];
        n_src_1[wr] = e_src_1[i];
        n_src_2[wr] = e_src_2[i];
        n_imm[wr]   = e_imm[i];
        n_rrn[wr]   = e_rrn[i];
        n_tag[wr]   = e_tag[i];
        {n_valid_1[wr], n_data_1[wr]} = capture(e_src_1[i], e_valid_1[i], e_data_1[i]);
        {n_valid_2[wr], n_data_2[wr]} = capture(e_src_2[i], e_valid_2[i], e_data_2[i]);
        wr++;
      end
    end
    // new instructions go behind, lane 0 first.
    for (int k = 0; k < 2; k++) begin
      if (issue_st_type[k] == ST_TYPE && !(delete_tagged && issue_tag[k]) &&
          wr < RS_SIZE) begin
        n_busy[wr]  = 1'b1;
        n_op[wr]    = issue_op[k];
        n_src_1[wr] = issue_src_1[k];
        n_src_2[wr] = issue_src_2[k];
        n_imm[wr]   = issue_imm[k];
        n_rrn[wr]   = issue_rrn[k];
        n_tag[wr]   = issue_tag[k];
        {n_valid_1[wr], n_data_1[wr]} = capture(issue_src_1[k], issue_valid_1[k],
                                                issue_data_1[k]);
        {n_valid_2[wr], n_data_2[wr]} = capture(issue_src_2[k], issue_valid_2[k],
                                                issue_data_2[k]);
        wr++;
      end
    end
  end

  always_ff @(posedge gsi) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (rst) begin
        e_busy[i] <= 1'b0;
      end else begin
        e_busy[i] <= n_busy[i];
      end
    end
  end

  always_ff @(posedge gsi) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      e_op[i]      <= n_op[i];
      e_src_1[i]   <= n_src_1[i];
      e_src_2[i]   <= n_src_2[i];
      e_valid_1[i] <= n_valid_1[i];
      e_valid_2[i] <= n_valid_2[i];
      e_data_1[i]  <= n_data_1[i];
      e_data_2[i]  <= n_data_2[i];
      e_imm[i]     <= n_imm[i];
      e_rrn[i]     <= n_rrn[i];
      e_tag[i]     <= n_tag[i];
    end
  end

  // ====================
  // feed
  // ====================
  always_ff @(posedge gsi) begin
    if (rst) begin
      feed_valid <= 1'b0;
    end else begin
      feed_valid <= sel_any;
    end
  end

  always_ff @(posedge gsi) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (sel[i]) begin
        feed_op     <= e_op[i];
        feed_data_1 <= e_data_1[i];
        feed_data_2 <= e_data_2[i];
        feed_imm    <= e_imm[i];
        feed_rrn    <= e_rrn[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/ooo_pkg.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/exec_cluster.sv
tests/exec_cluster_assertions.sv
tests/tb_exec_cluster.sv
